// File: Makefile
VERILATOR ?= verilator
TOP       ?= pwmPlayerTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out=$$(./$(BUILD_DIR)/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// File: pwmPkg.sv
`default_nettype none

package pwmPkg;

    // sample and pwm count
    localparam int SAMPLE_WIDTH = 8;

    // clocksPerCycle and step counter
    localparam int STEP_WIDTH = 16;

    // pwm periods played per sample
    localparam int REPEAT_COUNT = 8;
    localparam int REPEAT_WIDTH = 4;

    // sample queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_WIDTH = 2;

endpackage

`default_nettype wire

// File: pwmPlayer.sv
`timescale 1ns/1ps
`default_nettype none

module pwmPlayer import pwmPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [STEP_WIDTH-1:0]   clocksPerCycle,
    input  logic                    sampleReq,
    input  logic [SAMPLE_WIDTH-1:0] sampleData,
    output logic                    sampleAck,
    output logic                    pwmOut,
    output logic                    underrun
);

    logic                    push;
    logic [SAMPLE_WIDTH-1:0] pushData;
    logic                    full;
    logic                    readReq;
    logic [SAMPLE_WIDTH-1:0] fifoData;

    sampleReceiver receiver (
        .clk        (clk),
        .reset      (reset),
        .sampleReq  (sampleReq),
        .sampleData (sampleData),
        .sampleAck  (sampleAck),
        .push       (push),
        .pushData   (pushData),
        .full       (full)
    );

    sampleFifo fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .pushData (pushData),
        .full     (full),
        .readReq  (readReq),
        .dataOut  (fifoData),
        .underrun (underrun)
    );

    pwmUnit pwm (
        .clk            (clk),
        .reset          (reset),
        .clocksPerCycle (clocksPerCycle),
        .dataIn         (fifoData),
        .pwmOut         (pwmOut),
        .readReq        (readReq)
    );

endmodule

`default_nettype wire

// File: pwmPlayerTb.sv
`timescale 1ns/1ps
`default_nettype none

module pwmPlayerTb import pwmPkg::*; ();

    localparam int CLOCKS_PER_CYCLE = 2;
    localparam int NUM_SAMPLES      = 10;
    localparam int PHASE_A          = 4;    // samples with random host delays
    localparam int NUM_GROUPS       = NUM_SAMPLES + 3;   // reset group plus two underrun groups
    localparam int WINDOW_CYCLES    = (1 << SAMPLE_WIDTH) * CLOCKS_PER_CYCLE;
    localparam int SAMPLE_CYCLES    = REPEAT_COUNT * WINDOW_CYCLES;
    localparam int TIMEOUT_CYCLES   = 14 * SAMPLE_CYCLES + 2000;

    logic                    clk;
    logic                    reset;
    logic [STEP_WIDTH-1:0]   clocksPerCycle;
    logic                    sampleReq;
    logic [SAMPLE_WIDTH-1:0] sampleData;
    logic                    sampleAck;
    logic                    pwmOut;
    logic                    underrun;

    logic [31:0]             lfsrState;
    logic [SAMPLE_WIDTH-1:0] samples [NUM_SAMPLES];
    int                      delays [NUM_SAMPLES];
    logic [SAMPLE_WIDTH-1:0] modelQueue [$];
    int                      ackCount;
    int                      maxWait;
    int                      cycleCount;
    logic                    hostDone;
    logic                    ackSeen;
    logic                    reqSeen;

    pwmPlayer UUT (
        .clk            (clk),
        .reset          (reset),
        .clocksPerCycle (clocksPerCycle),
        .sampleReq      (sampleReq),
        .sampleData     (sampleData),
        .sampleAck      (sampleAck),
        .pwmOut         (pwmOut),
        .underrun       (underrun)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrBit();
        logic feedback;
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic int randomBits(input int width);
        int value;
        int i;
        value = 0;
        for (i = 0; i < width; i++) begin
            value = (value << 1) | int'(lfsrBit());
        end
        return value;
    endfunction

    task automatic failRun(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s actual %0d expected %0d",
                     $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // one four-phase transfer, starts and ends on a rising edge
    task automatic sendSample(input logic [SAMPLE_WIDTH-1:0] value, output int waited);
        waited = 0;
        sampleReq  <= 1'b1;
        sampleData <= value;
        @(posedge clk);
        while (!sampleAck) begin
            waited++;
            @(posedge clk);
        end
        sampleReq <= 1'b0;
        @(posedge clk);
        while (sampleAck) begin
            @(posedge clk);
        end
    endtask

    task automatic runHost();
        int waited;
        int i;
        for (i = 0; i < NUM_SAMPLES; i++) begin
            repeat (delays[i]) @(posedge clk);
            sendSample(samples[i], waited);
            if (i >= PHASE_A && waited > maxWait) begin
                maxWait = waited;   // burst runs into a full FIFO
            end
        end
        hostDone = 1'b1;
    endtask

    // handshake monitor, also feeds the model queue
    task automatic watchCycle();
        @(negedge clk);
        if (sampleAck && !ackSeen) begin
            check("sampleReq at ack rise", int'(sampleReq), 1);
            check("sampleReq before ack rise", int'(reqSeen), 1);
            if (ackCount >= NUM_SAMPLES) begin
                failRun("more acknowledges than requests");
            end
            check("sampleData", int'(sampleData), int'(samples[ackCount]));
            modelQueue.push_back(sampleData);
            ackCount++;
        end
        if (!sampleAck && ackSeen) begin
            check("sampleReq before ack fall", int'(reqSeen), 0);
        end
        ackSeen = sampleAck;
        reqSeen = sampleReq;
    endtask

    task automatic checkIdle();
        check("pwmOut", int'(pwmOut), 1);
        check("sampleAck", int'(sampleAck), 0);
        check("underrun", int'(underrun), 0);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            cycleCount++;
            if (cycleCount >= TIMEOUT_CYCLES) begin
                $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
                $display("Testbench failed");
                $fatal(1);
            end
        end
    end

    initial begin
        int group;
        int window;
        int cycle;
        int highCount;
        int limit;
        int underrunExp;
        int i;

        reset          = 1'b1;
        clocksPerCycle = STEP_WIDTH'(CLOCKS_PER_CYCLE);
        sampleReq      = 1'b0;
        sampleData     = '0;
        lfsrState      = 32'h43d782d4;
        ackCount       = 0;
        maxWait        = 0;
        cycleCount     = 0;
        hostDone       = 1'b0;
        ackSeen        = 1'b0;
        reqSeen        = 1'b0;

        for (i = 0; i < NUM_SAMPLES; i++) begin
            samples[i] = SAMPLE_WIDTH'(randomBits(SAMPLE_WIDTH));
            delays[i]  = (i < PHASE_A) ? randomBits(4) : 0;
        end
        samples[1] = '0;    // extremes of the duty range
        samples[3] = '1;

        repeat (15) @(posedge clk);
        @(negedge clk);
        checkIdle();
        @(posedge clk);
        reset <= 1'b0;
        fork
            runHost();
        join_none

        watchCycle();
        checkIdle();

        // windows start one cycle after the first edge out of reset
        limit       = 0;
        underrunExp = 0;
        for (group = 0; group < NUM_GROUPS; group++) begin
            if (group > 0) begin
                if (modelQueue.size() > 0) begin
                    limit = int'(modelQueue.pop_front());
                end else begin
                    underrunExp = 1;    // head held, limit unchanged
                end
            end
            for (window = 0; window < REPEAT_COUNT; window++) begin
                highCount = 0;
                for (cycle = 0; cycle < WINDOW_CYCLES; cycle++) begin
                    watchCycle();
                    if (cycle == 0) begin
                        check("underrun", int'(underrun), underrunExp);
                    end
                    if (pwmOut) begin
                        highCount++;
                    end
                end
                check("pwmOut high cycles", highCount, (limit + 1) * CLOCKS_PER_CYCLE);
            end
        end

        check("hostDone", int'(hostDone), 1);
        check("ackCount", ackCount, NUM_SAMPLES);
        check("burst ack delayed", int'(maxWait > WINDOW_CYCLES), 1);
        check("underrun", int'(underrun), 1);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: pwmUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pwmUnit import pwmPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [STEP_WIDTH-1:0]   clocksPerCycle,
    input  logic [SAMPLE_WIDTH-1:0] dataIn,
    output logic                    pwmOut,
    output logic                    readReq
);

    localparam logic [SAMPLE_WIDTH-1:0] COUNT_LAST = '1;
    localparam logic [SAMPLE_WIDTH-1:0] COUNT_REQ  = COUNT_LAST - 1'b1;
    localparam logic [REPEAT_WIDTH-1:0] REPEAT_LAST = REPEAT_WIDTH'(REPEAT_COUNT);

    logic [REPEAT_WIDTH-1:0] repeatCount;
    logic [REPEAT_WIDTH-1:0] repeatCountNext;
    logic [SAMPLE_WIDTH-1:0] pwmCount;
    logic [SAMPLE_WIDTH-1:0] pwmCountNext;
    logic [SAMPLE_WIDTH-1:0] pwmLimit;
    logic [SAMPLE_WIDTH-1:0] pwmLimitNext;
    logic [STEP_WIDTH-1:0]   stepCount;
    logic [STEP_WIDTH-1:0]   stepCountNext;
    logic                    stepTick;
    logic                    pwmOutNext;

    // periods played for the current sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            repeatCount <= REPEAT_WIDTH'(1);
        end else begin
            repeatCount <= repeatCountNext;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwmCount <= '0;
        end else begin
            pwmCount <= pwmCountNext;
        end
    end

    // duty limit, zero until the first sample loads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwmLimit <= '0;
        end else begin
            pwmLimit <= pwmLimitNext;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stepCount <= STEP_WIDTH'(1);
        end else begin
            stepCount <= stepCountNext;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwmOut <= 1'b1;
        end else begin
            pwmOut <= pwmOutNext;
        end
    end

    assign stepTick = (stepCount >= clocksPerCycle);

    always_comb begin
        repeatCountNext = repeatCount;
        pwmCountNext    = pwmCount;
        pwmLimitNext    = pwmLimit;
        stepCountNext   = stepCount + 1'b1;
        readReq         = 1'b0;

        if (stepTick) begin
            stepCountNext = STEP_WIDTH'(1);
            pwmCountNext  = pwmCount + 1'b1;   // wraps 255 -> 0

            if (repeatCount == REPEAT_LAST) begin
                if (pwmCount == COUNT_REQ) begin
                    readReq = 1'b1;            // fifo head ready a tick later
                end
                if (pwmCount == COUNT_LAST) begin
                    pwmLimitNext    = dataIn;
                    repeatCountNext = REPEAT_WIDTH'(1);
                end
            end else if (pwmCount == COUNT_LAST) begin
                repeatCountNext = repeatCount + 1'b1;
            end
        end

        // high for limit + 1 steps per period
        pwmOutNext = (pwmCount <= pwmLimit);
    end

    // a zero step length would stall the counters at a tick every cycle
    assert property (@(posedge clk) disable iff (reset) clocksPerCycle != '0)
        else $error("clocksPerCycle is zero");

endmodule

`default_nettype wire

// File: sampleFifo.sv
`timescale 1ns/1ps
`default_nettype none

module sampleFifo import pwmPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  logic [SAMPLE_WIDTH-1:0] pushData,
    output logic                    full,
    input  logic                    readReq,
    output logic [SAMPLE_WIDTH-1:0] dataOut,
    output logic                    underrun
);

    logic [SAMPLE_WIDTH-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wrPtr;
    logic [FIFO_PTR_WIDTH-1:0] rdPtr;
    logic [FIFO_PTR_WIDTH:0]   count;
    logic                      empty;
    logic                      doPush;
    logic                      doPop;

    assign full   = (count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign empty  = (count == '0);
    assign doPush = push && !full;
    assign doPop  = readReq && !empty;

    // storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // write pointer, wraps with the depth
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wrPtr <= '0;
        end else if (doPush) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    // read pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdPtr <= '0;
        end else if (doPop) begin
            rdPtr <= rdPtr + 1'b1;
        end
    end

    // occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // registered head, holds on an empty pop
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dataOut <= '0;
        end else if (doPop) begin
            dataOut <= mem[rdPtr];
        end
    end

    // sticky until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            underrun <= 1'b0;
        end else if (readReq && empty) begin
            underrun <= 1'b1;
        end
    end

    // a push into a full queue would be lost
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("sample pushed into a full FIFO");

endmodule

`default_nettype wire

// File: sampleReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module sampleReceiver import pwmPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sampleReq,
    input  logic [SAMPLE_WIDTH-1:0] sampleData,
    output logic                    sampleAck,
    output logic                    push,
    output logic [SAMPLE_WIDTH-1:0] pushData,
    input  logic                    full
);

    typedef enum logic {
        waitReq,
        waitRelease
    } stateType;

    stateType state;
    stateType stateNext;
    logic     sampleAckNext;

    // handshake state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= waitReq;
        end else begin
            state <= stateNext;
        end
    end

    // ack follows the state, registered
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sampleAck <= 1'b0;
        end else begin
            sampleAck <= sampleAckNext;
        end
    end

    always_comb begin
        stateNext     = state;
        sampleAckNext = sampleAck;
        push          = 1'b0;

        case (state)
            waitReq: begin
                if (sampleReq && !full) begin   // wait out back-pressure
                    push          = 1'b1;
                    sampleAckNext = 1'b1;
                    stateNext     = waitRelease;
                end
            end
            waitRelease: begin
                if (!sampleReq) begin           // host released, drop ack
                    sampleAckNext = 1'b0;
                    stateNext     = waitReq;
                end
            end
            default: begin
                stateNext = waitReq;
            end
        endcase
    end

    assign pushData = sampleData;   // stable while sampleReq is high

    // host keeps the data steady while it holds the request
    assert property (@(posedge clk) disable iff (reset)
        sampleReq && $past(sampleReq) |-> $stable(sampleData))
        else $error("sampleData changed while sampleReq was held");

endmodule

`default_nettype wire

// File: src.f
pwmPkg.sv
sampleReceiver.sv
sampleFifo.sv
pwmUnit.sv
pwmPlayer.sv
pwmPlayerTb.sv
